/* compile.f */
cpu_pkg.sv
board_pkg.sv
mem_bus_if.sv
flash_ctrl.sv
bootloader.sv
unified_ram.sv
zhxpu_core.sv
dig_ctrl.sv
zhxpu.sv
tb_zhxpu.sv

/* tb_zhxpu.sv */
`timescale 1ns/1ns

module tb_zhxpu;
	import cpu_pkg::*;
	import board_pkg::*;

	localparam int FLASH_WAIT = 3;
	localparam int BOOT_WORDS = 32;
	localparam int RAM_ADDR_W = 8;
	localparam int FLASH_DEPTH = 64;
	localparam int NUM_TESTS = 5;
	localparam int TIMEOUT_CYCLES =
		NUM_TESTS * (BOOT_WORDS * (FLASH_WAIT + 4) + 3 * 64) + 100;
	// Not in the opcode table
	localparam logic [OP_W-1:0] OP_ILLEGAL = 5'h1f;

	logic clk;
	logic arst_n;
	logic [15:0] sw;
	word_t flash_data;
	flash_addr_t flash_addr;
	logic flash_ce;
	logic flash_oe;
	logic [6:0] seg1;
	logic [6:0] seg2;
	word_t led;
	logic boot_done;
	logic halted;

	word_t flash_mem [FLASH_DEPTH];
	word_t exp_regs [NUM_REGS];
	flash_addr_t oe_addrs [$];
	int wr_ptr;
	int errors;
	int checks;
	int cycle_count;
	integer seed;

	zhxpu #(
		.FLASH_WAIT(FLASH_WAIT),
		.BOOT_WORDS(BOOT_WORDS),
		.RAM_ADDR_W(RAM_ADDR_W)
	) dut (
		.clk(clk),
		.arst_n(arst_n),
		.flash_data(flash_data),
		.sw(sw),
		.flash_addr(flash_addr),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.seg1(seg1),
		.seg2(seg2),
		.led(led),
		.boot_done(boot_done),
		.halted(halted)
	);

	// Flash chip drives the bus only while selected and read-enabled
	assign flash_data = (!flash_ce && !flash_oe) ? flash_mem[flash_addr] : 'x;

	always #2 clk = ~clk;

	// End of each flash access
	always @(posedge flash_oe) begin
		if (arst_n === 1'b1) begin
			oe_addrs.push_back(flash_addr);
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic check_addr(input string name, input flash_addr_t expected,
			input flash_addr_t actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	function automatic word_t build_imm8(input logic [OP_W-1:0] op, input reg_addr_t rx,
			input logic [IMM8_W-1:0] imm);
		word_t w;
		w = '0;
		w[OP_POS +: OP_W] = op;
		w[RX_POS +: REG_W] = rx;
		w[IMM8_W-1:0] = imm;
		return w;
	endfunction

	function automatic word_t build_alu(input logic [OP_W-1:0] op, input reg_addr_t rx,
			input reg_addr_t ry, input reg_addr_t rz);
		word_t w;
		w = '0;
		w[OP_POS +: OP_W] = op;
		w[RX_POS +: REG_W] = rx;
		w[RY_POS +: REG_W] = ry;
		w[RZ_POS +: REG_W] = rz;
		return w;
	endfunction

	function automatic word_t build_mem(input logic [OP_W-1:0] op, input reg_addr_t rx,
			input reg_addr_t ry, input logic [IMM5_W-1:0] imm);
		word_t w;
		w = '0;
		w[OP_POS +: OP_W] = op;
		w[RX_POS +: REG_W] = rx;
		w[RY_POS +: REG_W] = ry;
		w[IMM5_W-1:0] = imm;
		return w;
	endfunction

	function automatic word_t build_jump(input logic [IMM11_W-1:0] imm);
		word_t w;
		w = '0;
		w[OP_POS +: OP_W] = OP_B;
		w[IMM11_W-1:0] = imm;
		return w;
	endfunction

	// Segments {g, f, e, d, c, b, a} back to a hex digit
	function automatic logic [3:0] seg_digit(input logic [6:0] light);
		case (light)
			7'h3f: return 4'h0;
			7'h06: return 4'h1;
			7'h5b: return 4'h2;
			7'h4f: return 4'h3;
			7'h66: return 4'h4;
			7'h6d: return 4'h5;
			7'h7d: return 4'h6;
			7'h07: return 4'h7;
			7'h7f: return 4'h8;
			7'h6f: return 4'h9;
			7'h77: return 4'ha;
			7'h7c: return 4'hb;
			7'h39: return 4'hc;
			7'h5e: return 4'hd;
			7'h79: return 4'he;
			7'h71: return 4'hf;
			default: return 4'bxxxx;
		endcase
	endfunction

	function automatic word_t display_value();
		return {8'h00, seg_digit(seg1), seg_digit(seg2)};
	endfunction

	task automatic clear_image();
		for (int i = 0; i < FLASH_DEPTH; i++) begin
			flash_mem[i] = '0;
		end
		for (int i = 0; i < NUM_REGS; i++) begin
			exp_regs[i] = '0;
		end
		wr_ptr = 0;
	endtask

	task automatic append_word(input word_t w);
		flash_mem[wr_ptr] = w;
		wr_ptr++;
	endtask

	task automatic pulse_reset();
		@(posedge clk);
		#1;
		arst_n = 1'b0;
		oe_addrs.delete();
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
	endtask

	task automatic wait_for_halt(input string name);
		while (halted !== 1'b1) begin
			@(negedge clk);
		end
		check_bit({name, " boot_done"}, 1'b1, boot_done);
	endtask

	task automatic read_register(input reg_addr_t sel, output word_t value);
		@(posedge clk);
		#1;
		sw = {13'b0, sel};
		@(negedge clk);
		value = led;
	endtask

	task automatic compare_registers(input string name);
		word_t value;
		for (int i = 0; i < NUM_REGS; i++) begin
			read_register(reg_addr_t'(i), value);
			check_word($sformatf("%s r%0d", name, i), exp_regs[i], value);
		end
	endtask

	task automatic test_boot();
		clear_image();
		append_word(build_imm8(OP_ILLEGAL, 3'd0, 8'h00));
		pulse_reset();
		check_bit("boot flash_ce", 1'b1, flash_ce);
		check_bit("boot flash_oe", 1'b1, flash_oe);
		check_bit("boot boot_done", 1'b0, boot_done);
		check_bit("boot halted", 1'b0, halted);
		while (boot_done !== 1'b1) begin
			@(negedge clk);
		end
		check_word("boot read_count", word_t'(BOOT_WORDS), word_t'(oe_addrs.size()));
		for (int i = 0; i < BOOT_WORDS && i < oe_addrs.size(); i++) begin
			check_addr($sformatf("boot read %0d", i), flash_addr_t'(i), oe_addrs[i]);
		end
		wait_for_halt("boot");
	endtask

	task automatic test_alu();
		logic [31:0] rnd;
		logic [7:0] imm_a;
		logic [7:0] imm_b;
		logic [7:0] imm_c;
		logic [7:0] imm_neg;
		clear_image();
		rnd = $random(seed);
		imm_a = rnd[7:0];
		rnd = $random(seed);
		imm_b = rnd[7:0];
		rnd = $random(seed);
		imm_c = rnd[7:0];
		rnd = $random(seed);
		imm_neg = rnd[7:0] | 8'h80;
		append_word(build_imm8(OP_LI, 3'd1, imm_a));
		append_word(build_imm8(OP_LI, 3'd2, imm_b));
		append_word(build_imm8(OP_LI, 3'd3, imm_c));
		append_word(build_imm8(OP_ADDIU, 3'd3, imm_neg));
		append_word(build_alu(OP_ADDU, 3'd1, 3'd2, 3'd4));
		append_word(build_alu(OP_SUBU, 3'd1, 3'd2, 3'd5));
		append_word(build_alu(OP_AND, 3'd1, 3'd3, 3'd6));
		append_word(build_alu(OP_OR, 3'd2, 3'd3, 3'd7));
		append_word(build_alu(OP_SUBU, 3'd3, 3'd1, 3'd0));
		append_word(build_imm8(OP_ILLEGAL, 3'd0, 8'h00));
		exp_regs[1] = {8'h00, imm_a};
		exp_regs[2] = {8'h00, imm_b};
		exp_regs[3] = {8'h00, imm_c} + {{8{imm_neg[7]}}, imm_neg};
		exp_regs[4] = exp_regs[1] + exp_regs[2];
		exp_regs[5] = exp_regs[1] - exp_regs[2];
		exp_regs[6] = exp_regs[1] & exp_regs[3];
		exp_regs[7] = exp_regs[2] | exp_regs[3];
		exp_regs[0] = exp_regs[3] - exp_regs[1];
		pulse_reset();
		wait_for_halt("alu");
		compare_registers("alu");
	endtask

	task automatic test_memory();
		clear_image();
		// Base 0x50 with offsets -16 and -15
		append_word(build_imm8(OP_LI, 3'd1, 8'h50));
		append_word(build_imm8(OP_LI, 3'd2, 8'ha5));
		append_word(build_imm8(OP_LI, 3'd3, 8'h3c));
		append_word(build_mem(OP_SW, 3'd1, 3'd2, 5'h10));
		append_word(build_mem(OP_SW, 3'd1, 3'd3, 5'h11));
		append_word(build_mem(OP_LW, 3'd1, 3'd4, 5'h10));
		append_word(build_mem(OP_LW, 3'd1, 3'd5, 5'h11));
		// Plain base 0x40 shows where the stores landed
		append_word(build_imm8(OP_LI, 3'd6, 8'h40));
		append_word(build_mem(OP_LW, 3'd6, 3'd7, 5'h01));
		append_word(build_imm8(OP_ILLEGAL, 3'd0, 8'h00));
		exp_regs[1] = 16'h0050;
		exp_regs[2] = 16'h00a5;
		exp_regs[3] = 16'h003c;
		exp_regs[4] = 16'h00a5;
		exp_regs[5] = 16'h003c;
		exp_regs[6] = 16'h0040;
		exp_regs[7] = 16'h003c;
		pulse_reset();
		wait_for_halt("memory");
		compare_registers("memory");
	endtask

	task automatic test_branches();
		clear_image();
		append_word(build_imm8(OP_LI, 3'd1, 8'h00));
		append_word(build_imm8(OP_LI, 3'd2, 8'h07));
		append_word(build_imm8(OP_BEQZ, 3'd2, 8'h01));
		append_word(build_imm8(OP_LI, 3'd3, 8'h11));
		append_word(build_imm8(OP_BEQZ, 3'd1, 8'h01));
		append_word(build_imm8(OP_LI, 3'd4, 8'h22));
		append_word(build_imm8(OP_LI, 3'd5, 8'h05));
		append_word(build_imm8(OP_LI, 3'd6, 8'h00));
		// Loop body at word 8
		append_word(build_imm8(OP_ADDIU, 3'd5, 8'hff));
		append_word(build_imm8(OP_ADDIU, 3'd6, 8'h01));
		append_word(build_imm8(OP_BEQZ, 3'd5, 8'h01));
		append_word(build_jump(11'h7fc));
		append_word(build_imm8(OP_ILLEGAL, 3'd0, 8'h00));
		exp_regs[2] = 16'h0007;
		exp_regs[3] = 16'h0011;
		exp_regs[6] = 16'h0005;
		pulse_reset();
		wait_for_halt("branch");
		compare_registers("branch");
	endtask

	task automatic test_illegal_halt();
		word_t value;
		clear_image();
		append_word(build_imm8(OP_LI, 3'd1, 8'h33));
		wr_ptr = 27;
		append_word(build_imm8(OP_ILLEGAL, 3'd0, 8'h00));
		append_word(build_imm8(OP_LI, 3'd2, 8'h44));
		exp_regs[1] = 16'h0033;
		pulse_reset();
		wait_for_halt("halt");
		@(negedge clk);
		check_word("halt display", 16'h001b, display_value());
		repeat (20) begin
			@(negedge clk);
			check_bit("halt hold", 1'b1, halted);
			check_word("halt hold display", 16'h001b, display_value());
		end
		read_register(3'd2, value);
		check_word("halt r2", 16'h0000, value);
		compare_registers("halt");
	endtask

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		sw = '0;
		seed = 8;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		wr_ptr = 0;
		test_boot();
		test_alu();
		test_memory();
		test_branches();
		test_illegal_halt();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* zhxpu.sv */
`timescale 1ns/1ns

module zhxpu #(
	parameter int FLASH_WAIT = 3,
	parameter int BOOT_WORDS = 32,
	parameter int RAM_ADDR_W = 8
) (
	input logic clk,
	input logic arst_n,
	input logic [15:0] flash_data,
	input logic [15:0] sw,
	output logic [22:0] flash_addr,
	output logic flash_ce,
	output logic flash_oe,
	output logic [6:0] seg1,
	output logic [6:0] seg2,
	output logic [15:0] led,
	output logic boot_done,
	output logic halted
);
	import cpu_pkg::*;
	import board_pkg::*;

	logic rd_req;
	logic rd_done;
	flash_addr_t rd_addr;
	word_t rd_data;
	word_t boot_addr;
	word_t pc;
	logic [3:0] dig1_data;
	logic [3:0] dig2_data;

	mem_bus_if #(.RAM_ADDR_W(RAM_ADDR_W)) boot_bus ();
	mem_bus_if #(.RAM_ADDR_W(RAM_ADDR_W)) core_bus ();

	flash_ctrl #(.FLASH_WAIT(FLASH_WAIT)) __flash_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.flash_data(flash_data),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.flash_addr(flash_addr),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe)
	);

	bootloader #(.BOOT_WORDS(BOOT_WORDS), .RAM_ADDR_W(RAM_ADDR_W)) __bootloader (
		.clk(clk),
		.arst_n(arst_n),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.boot_done(boot_done),
		.boot_addr(boot_addr),
		.ram(boot_bus.master)
	);

	unified_ram #(.RAM_ADDR_W(RAM_ADDR_W)) __unified_ram (
		.clk(clk),
		.boot_done(boot_done),
		.boot(boot_bus.slave),
		.core(core_bus.slave)
	);

	zhxpu_core #(.RAM_ADDR_W(RAM_ADDR_W)) __zhxpu_core (
		.clk(clk),
		.arst_n(arst_n),
		.boot_done(boot_done),
		.dbg_sel(sw[2:0]),
		.mem(core_bus.master),
		.pc(pc),
		.dbg_value(led),
		.halted(halted)
	);

	// Boot progress first, then the program counter
	assign dig1_data = boot_done ? pc[7:4] : boot_addr[7:4];
	assign dig2_data = boot_done ? pc[3:0] : boot_addr[3:0];

	dig_ctrl __dig_ctrl_1 (
		.dig(dig1_data),
		.light(seg1)
	);

	dig_ctrl __dig_ctrl_2 (
		.dig(dig2_data),
		.light(seg2)
	);

endmodule

/* dig_ctrl.sv */
`timescale 1ns/1ns

module dig_ctrl (
	input logic [3:0] dig,
	output logic [6:0] light
);
	// Lit segments are high in bit order {g, f, e, d, c, b, a}
	always_comb begin
		case (dig)
			4'h0: light = 7'b0111111;
			4'h1: light = 7'b0000110;
			4'h2: light = 7'b1011011;
			4'h3: light = 7'b1001111;
			4'h4: light = 7'b1100110;
			4'h5: light = 7'b1101101;
			4'h6: light = 7'b1111101;
			4'h7: light = 7'b0000111;
			4'h8: light = 7'b1111111;
			4'h9: light = 7'b1101111;
			4'ha: light = 7'b1110111;
			4'hb: light = 7'b1111100;
			4'hc: light = 7'b0111001;
			4'hd: light = 7'b1011110;
			4'he: light = 7'b1111001;
			default: light = 7'b1110001;
		endcase
	end

endmodule

/* zhxpu_core.sv */
`timescale 1ns/1ns

module zhxpu_core #(
	parameter int RAM_ADDR_W = 8
) (
	input logic clk,
	input logic arst_n,
	input logic boot_done,
	input cpu_pkg::reg_addr_t dbg_sel,
	mem_bus_if.master mem,
	output cpu_pkg::word_t pc,
	output cpu_pkg::word_t dbg_value,
	output logic halted
);
	import cpu_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_FETCH,
		S_EXEC,
		S_MEM
	} core_state_t;

	core_state_t state;
	word_t regs [NUM_REGS];
	word_t ir;
	word_t inst;
	opcode_t opcode;
	reg_addr_t rx;
	reg_addr_t ry;
	reg_addr_t rz;
	word_t rx_val;
	word_t ry_val;
	word_t imm8_zext;
	word_t imm8_sext;
	word_t imm5_sext;
	word_t imm11_sext;
	word_t pc_inc;
	word_t pc_next;
	word_t ea;
	logic is_mem;
	logic legal;
	logic reg_we;
	reg_addr_t reg_wa;
	word_t reg_wd;

	// Fetched word is live on done, the memory phase uses the latched copy
	assign inst = (state == S_MEM) ? ir : mem.rdata;

	assign opcode = opcode_t'(inst[OP_POS +: OP_W]);
	assign rx = inst[RX_POS +: REG_W];
	assign ry = inst[RY_POS +: REG_W];
	assign rz = inst[RZ_POS +: REG_W];
	assign rx_val = regs[rx];
	assign ry_val = regs[ry];

	assign imm8_zext = {{(WORD_W - IMM8_W){1'b0}}, inst[IMM8_W-1:0]};
	assign imm8_sext = {{(WORD_W - IMM8_W){inst[IMM8_W-1]}}, inst[IMM8_W-1:0]};
	assign imm5_sext = {{(WORD_W - IMM5_W){inst[IMM5_W-1]}}, inst[IMM5_W-1:0]};
	assign imm11_sext = {{(WORD_W - IMM11_W){inst[IMM11_W-1]}}, inst[IMM11_W-1:0]};

	assign pc_inc = pc + word_t'(1);
	assign ea = rx_val + imm5_sext;
	assign is_mem = (opcode == OP_LW) || (opcode == OP_SW);

	// Decode and ALU
	always_comb begin
		reg_we = 1'b0;
		reg_wa = rx;
		reg_wd = '0;
		pc_next = pc_inc;
		legal = 1'b1;
		case (opcode)
			OP_NOP, OP_LW, OP_SW: begin
				reg_we = 1'b0;
			end
			OP_LI: begin
				reg_we = 1'b1;
				reg_wd = imm8_zext;
			end
			OP_ADDIU: begin
				reg_we = 1'b1;
				reg_wd = rx_val + imm8_sext;
			end
			OP_ADDU: begin
				reg_we = 1'b1;
				reg_wa = rz;
				reg_wd = rx_val + ry_val;
			end
			OP_SUBU: begin
				reg_we = 1'b1;
				reg_wa = rz;
				reg_wd = rx_val - ry_val;
			end
			OP_AND: begin
				reg_we = 1'b1;
				reg_wa = rz;
				reg_wd = rx_val & ry_val;
			end
			OP_OR: begin
				reg_we = 1'b1;
				reg_wa = rz;
				reg_wd = rx_val | ry_val;
			end
			OP_BEQZ: begin
				if (rx_val == '0) begin
					pc_next = pc_inc + imm8_sext;
				end
			end
			OP_B: begin
				pc_next = pc_inc + imm11_sext;
			end
			default: legal = 1'b0;
		endcase
	end

	// Data request leaves in the same cycle as the fetch done
	assign mem.req = (state == S_FETCH) || (state == S_EXEC && mem.done && is_mem);
	assign mem.we = (state == S_EXEC) && (opcode == OP_SW);
	assign mem.addr = (state == S_FETCH) ? pc[RAM_ADDR_W-1:0] : ea[RAM_ADDR_W-1:0];
	assign mem.wdata = ry_val;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_IDLE;
			pc <= '0;
			halted <= 1'b0;
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else begin
			case (state)
				S_IDLE: begin
					if (boot_done && !halted) begin
						state <= S_FETCH;
					end
				end
				S_FETCH: state <= S_EXEC;
				S_EXEC: begin
					if (mem.done) begin
						if (!legal) begin
							halted <= 1'b1;
							state <= S_IDLE;
						end else begin
							pc <= pc_next;
							if (reg_we) begin
								regs[reg_wa] <= reg_wd;
							end
							state <= is_mem ? S_MEM : S_FETCH;
						end
					end
				end
				S_MEM: begin
					if (mem.done) begin
						if (opcode == OP_LW) begin
							regs[ry] <= mem.rdata;
						end
						state <= S_FETCH;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_EXEC && mem.done) begin
			ir <= mem.rdata;
		end
	end

	assign dbg_value = regs[dbg_sel];

endmodule

/* unified_ram.sv */
`timescale 1ns/1ns

module unified_ram #(
	parameter int RAM_ADDR_W = 8
) (
	input logic clk,
	input logic boot_done,
	mem_bus_if.slave boot,
	mem_bus_if.slave core
);
	import cpu_pkg::*;

	localparam int DEPTH = 2 ** RAM_ADDR_W;

	word_t mem [DEPTH];
	word_t rdata_q;
	logic sel_req;
	logic sel_we;
	logic [RAM_ADDR_W-1:0] sel_addr;
	word_t sel_wdata;
	logic boot_done_q;
	logic core_done_q;

	// Bootloader owns the RAM until boot_done
	always_comb begin
		if (boot_done) begin
			sel_req = core.req;
			sel_we = core.we;
			sel_addr = core.addr;
			sel_wdata = core.wdata;
		end else begin
			sel_req = boot.req;
			sel_we = boot.we;
			sel_addr = boot.addr;
			sel_wdata = boot.wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_req) begin
			if (sel_we) begin
				mem[sel_addr] <= sel_wdata;
			end
			rdata_q <= mem[sel_addr];
		end
	end

	always_ff @(posedge clk) begin
		boot_done_q <= boot.req && !boot_done;
		core_done_q <= core.req && boot_done;
	end

	assign boot.done = boot_done_q;
	assign core.done = core_done_q;
	assign boot.rdata = rdata_q;
	assign core.rdata = rdata_q;

endmodule

/* bootloader.sv */
`timescale 1ns/1ns

module bootloader #(
	parameter int BOOT_WORDS = 32,
	parameter int RAM_ADDR_W = 8
) (
	input logic clk,
	input logic arst_n,
	input logic rd_done,
	input cpu_pkg::word_t rd_data,
	output logic rd_req,
	output board_pkg::flash_addr_t rd_addr,
	output logic boot_done,
	output cpu_pkg::word_t boot_addr,
	mem_bus_if.master ram
);
	import cpu_pkg::*;
	import board_pkg::*;

	boot_state_t state;
	word_t addr_cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= BOOT_IDLE;
			addr_cnt <= '0;
			rd_req <= 1'b0;
			ram.req <= 1'b0;
		end else begin
			rd_req <= 1'b0;
			ram.req <= 1'b0;
			case (state)
				BOOT_IDLE: begin
					rd_req <= 1'b1;
					state <= BOOT_READ;
				end
				BOOT_READ: begin
					if (rd_done) begin
						ram.req <= 1'b1;
						state <= BOOT_WRITE;
					end
				end
				BOOT_WRITE: begin
					if (ram.done) begin
						if (addr_cnt == word_t'(BOOT_WORDS - 1)) begin
							state <= BOOT_DONE;
						end else begin
							addr_cnt <= addr_cnt + word_t'(1);
							rd_req <= 1'b1;
							state <= BOOT_READ;
						end
					end
				end
				default: state <= BOOT_DONE;
			endcase
		end
	end

	// Same word address in flash and RAM
	assign rd_addr = flash_addr_t'(addr_cnt);
	assign ram.addr = addr_cnt[RAM_ADDR_W-1:0];
	assign ram.we = 1'b1;
	// Flash controller keeps rd_data until its next read
	assign ram.wdata = rd_data;

	assign boot_addr = addr_cnt;
	assign boot_done = (state == BOOT_DONE);

endmodule

/* flash_ctrl.sv */
`timescale 1ns/1ns

module flash_ctrl #(
	parameter int FLASH_WAIT = 3
) (
	input logic clk,
	input logic arst_n,
	input logic rd_req,
	input board_pkg::flash_addr_t rd_addr,
	input cpu_pkg::word_t flash_data,
	output logic rd_done,
	output cpu_pkg::word_t rd_data,
	output board_pkg::flash_addr_t flash_addr,
	output logic flash_ce,
	output logic flash_oe
);
	localparam int CNT_W = (FLASH_WAIT > 1) ? $clog2(FLASH_WAIT) : 1;

	logic busy;
	logic [CNT_W-1:0] wait_cnt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			wait_cnt <= '0;
			rd_done <= 1'b0;
		end else begin
			rd_done <= 1'b0;
			if (busy) begin
				if (wait_cnt == '0) begin
					busy <= 1'b0;
					rd_done <= 1'b1;
				end else begin
					wait_cnt <= wait_cnt - 1'b1;
				end
			end else if (rd_req) begin
				busy <= 1'b1;
				wait_cnt <= CNT_W'(FLASH_WAIT - 1);
			end
		end
	end

	// Address held for the whole access, data taken on the last wait cycle
	always_ff @(posedge clk) begin
		if (!busy && rd_req) begin
			flash_addr <= rd_addr;
		end
		if (busy && wait_cnt == '0) begin
			rd_data <= flash_data;
		end
	end

	assign flash_ce = ~busy;
	assign flash_oe = ~busy;

endmodule

/* mem_bus_if.sv */
`timescale 1ns/1ns

interface mem_bus_if #(
	parameter int RAM_ADDR_W = 8
);
	import cpu_pkg::*;

	// One-cycle req answered by one-cycle done
	logic req;
	logic we;
	logic [RAM_ADDR_W-1:0] addr;
	word_t wdata;
	word_t rdata;
	logic done;

	modport master (output req, we, addr, wdata, input rdata, done);
	modport slave (input req, we, addr, wdata, output rdata, done);

endinterface

/* board_pkg.sv */
package board_pkg;

	localparam int FLASH_ADDR_W = 23;

	// Flash is addressed in 16-bit words
	typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;

	typedef enum logic [1:0] {
		BOOT_IDLE,
		BOOT_READ,
		BOOT_WRITE,
		BOOT_DONE
	} boot_state_t;

endpackage

/* cpu_pkg.sv */
package cpu_pkg;

	localparam int WORD_W = 16;
	localparam int REG_W = 3;
	localparam int NUM_REGS = 2 ** REG_W;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0] reg_addr_t;

	// Instruction fields as lowest bit and width
	localparam int OP_POS = 11;
	localparam int OP_W = 5;
	localparam int RX_POS = 8;
	localparam int RY_POS = 5;
	localparam int RZ_POS = 2;

	// Immediates sit in the low bits
	localparam int IMM5_W = 5;
	localparam int IMM8_W = 8;
	localparam int IMM11_W = 11;

	// All-zero word decodes as NOP
	typedef enum logic [OP_W-1:0] {
		OP_NOP   = 5'h00,
		OP_LI    = 5'h01,
		OP_ADDIU = 5'h02,
		OP_ADDU  = 5'h03,
		OP_SUBU  = 5'h04,
		OP_AND   = 5'h05,
		OP_OR    = 5'h06,
		OP_LW    = 5'h07,
		OP_SW    = 5'h08,
		OP_BEQZ  = 5'h09,
		OP_B     = 5'h0a
	} opcode_t;

endpackage
